/* src.f */
rtl/trace_pkg.sv
rtl/uart_pkg.sv
rtl/trace_ctrl.sv
rtl/hex_line_fmt.sv
rtl/char_fifo.sv
rtl/uart_tx.sv
rtl/cpu_trace.sv
testbench/tb_clock.sv
testbench/tb_cpu_trace.sv

/* Makefile */
TOP = tb_cpu_trace

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): src.f rtl/*.sv testbench/*.sv
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	rm -f sim.log
	-obj_dir/V$(TOP) | tee sim.log
	grep -q '^\*\*\* PASSED \*\*\*$$' sim.log

lint:
	verilator --lint-only --timing -Wall -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

/* testbench/tb_cpu_trace.sv */
module tb_cpu_trace import trace_pkg::*, uart_pkg::*;;

	localparam int NUM_RECS       = 16;
	localparam int REC_CHARS      = 4 * LINE_CHARS;
	localparam int RESET_TIMEOUT  = 20;
	localparam int RETIRE_TIMEOUT = 10000;
	localparam int STALL_LIMIT    = 20 * 10 * BAUD_DIV;
	localparam int IDLE_WINDOW    = 40 * 10 * BAUD_DIV;

	typedef logic [REC_CHARS-1:0][7:0] rec_text_t;

	logic       clk;
	logic       rst;
	trace_rec_t cpu;
	logic       halt;
	logic       tx;

	trace_rec_t recs [NUM_RECS + 1];
	uart_char_t exp_q [$];
	uart_char_t rx_q [$];
	int         n_retired = 0;
	int         chars_decoded = 0;
	int         n_compared = 0;
	logic       snap_due = 1'b0;

	tb_clock clock_i (
		.clk (clk),
		.rst (rst)
	);

	cpu_trace dut_i (
		.clk  (clk),
		.rst  (rst),
		.cpu  (cpu),
		.halt (halt),
		.tx   (tx)
	);

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	task automatic check_char(input uart_char_t got, input uart_char_t exp, input int idx);
		if (got !== exp) begin
			fail_run($sformatf("ERROR @ %0t: character %0d is 0x%02h, expected 0x%02h",
				$time, idx, got, exp));
		end
	endtask

	task automatic check_retire(input trace_rec_t got, input trace_rec_t exp, input int idx);
		if (got !== exp) begin
			fail_run($sformatf("ERROR @ %0t: retirement %0d is %h, expected %h",
				$time, idx, got, exp));
		end
	endtask

	function automatic uart_char_t hex_char(input logic [3:0] nib);
		uart_char_t c;
		if (nib <= 4'd9) begin
			c = "0" + {4'h0, nib};
		end else begin
			c = "A" + {4'h0, nib} - 8'd10;
		end
		return c;
	endfunction

	// Expected text of one record, index REC_CHARS-1 goes out first
	function automatic rec_text_t ref_text(input trace_rec_t rec);
		rec_text_t   text;
		logic [31:0] words [3];
		words[0] = rec.instr;
		words[1] = rec.mem_addr;
		words[2] = rec.mem_wdata;
		for (int f = 0; f < 3; f++) begin
			for (int d = 0; d < LINE_CHARS; d++) begin
				text[REC_CHARS - 1 - f * LINE_CHARS - d] = hex_char(words[f][31 - 4 * d -: 4]);
			end
		end
		for (int k = 3; k < LINE_CHARS; k++) begin
			text[k] = "0";
		end
		text[2] = rec.mem_wr ? "1" : "0";
		text[1] = 8'h0d;
		text[0] = 8'h0a;
		return text;
	endfunction

	task automatic queue_expected(input trace_rec_t rec);
		rec_text_t text;
		text = ref_text(rec);
		for (int k = REC_CHARS - 1; k >= 0; k--) begin
			exp_q.push_back(text[k]);
		end
	endtask

	// Core model
	initial begin
		int          seed;
		int          wait_cnt;
		logic [31:0] rnd;
		seed = 32'h71e0234d;
		cpu = '0;
		for (int i = 0; i <= NUM_RECS; i++) begin
			recs[i].instr     = $random(seed);
			recs[i].mem_addr  = $random(seed);
			recs[i].mem_wdata = $random(seed);
			rnd = $random(seed);
			recs[i].mem_wr = rnd[0];
			if (recs[i].instr[31:26] == HALT_OPCODE) begin
				recs[i].instr[31:26] = 6'h2a;
			end
		end
		recs[NUM_RECS].instr[31:26] = HALT_OPCODE;

		wait_cnt = 0;
		@(posedge clk);
		@(negedge clk);
		while (rst) begin
			if (tx !== 1'b1 || halt !== 1'b1) begin
				fail_run($sformatf("ERROR @ %0t: tx=%b halt=%b during reset", $time, tx, halt));
			end
			wait_cnt++;
			if (wait_cnt > RESET_TIMEOUT) begin
				fail_run("Reset was never released");
			end
			@(negedge clk);
		end
		if (tx !== 1'b1 || halt !== 1'b1) begin
			fail_run($sformatf("ERROR @ %0t: tx=%b halt=%b after reset", $time, tx, halt));
		end

		@(posedge clk);
		cpu <= recs[0];
		for (int idx = 0; idx < NUM_RECS; idx++) begin
			wait_cnt = 0;
			@(negedge clk);
			while (halt) begin
				wait_cnt++;
				if (wait_cnt > RETIRE_TIMEOUT) begin
					fail_run($sformatf("Timed out waiting for record %0d to retire", idx));
				end
				@(negedge clk);
			end
			@(posedge clk);
			cpu <= recs[idx + 1];
		end

		wait_cnt = 0;
		while (exp_q.size() != 0 || rx_q.size() != 0) begin
			wait_cnt++;
			if (wait_cnt > RETIRE_TIMEOUT) begin
				fail_run("Timed out waiting for the trace text to drain");
			end
			@(negedge clk);
		end

		// Halt record stays presented through the whole window
		for (int c = 0; c < IDLE_WINDOW; c++) begin
			@(negedge clk);
			if (tx !== 1'b1 || halt !== 1'b1) begin
				fail_run($sformatf("ERROR @ %0t: tx=%b halt=%b after last character",
					$time, tx, halt));
			end
		end

		if (chars_decoded != REC_CHARS * NUM_RECS || exp_q.size() != 0) begin
			fail_run($sformatf("ERROR @ %0t: %0d characters decoded, expected %0d",
				$time, chars_decoded, REC_CHARS * NUM_RECS));
		end else begin
			$display("*** PASSED ***");
			$finish;
		end
	end

	// Retirement happens at the next rising edge
	always @(negedge clk) begin
		// Formatter holds the record granted one edge earlier
		if (snap_due) begin
			check_retire(dut_i.fmt_i.snap, recs[n_retired - 1], n_retired - 1);
			snap_due = 1'b0;
		end
		if (!rst && !halt) begin
			if (n_retired >= NUM_RECS) begin
				fail_run("Core was granted a record after the halt opcode");
			end
			if (chars_decoded + UART_CREDITS < REC_CHARS * n_retired) begin
				fail_run("Core was granted while text of the previous record was still queued");
			end
			queue_expected(cpu);
			n_retired++;
			snap_due = 1'b1;
		end
	end

	// Serial decoder, sampling half a clock after each tx change
	initial begin
		uart_char_t data;
		int         idle_cnt;
		forever begin
			idle_cnt = 0;
			@(negedge clk);
			while (tx !== 1'b0) begin
				idle_cnt++;
				if (idle_cnt > STALL_LIMIT) begin
					if (exp_q.size() != 0) begin
						fail_run("Serial line stayed idle with characters still expected");
					end
					idle_cnt = 0;
				end
				@(negedge clk);
			end
			if (n_retired == 0) begin
				fail_run("Start bit seen before the first retirement");
			end
			repeat (BAUD_DIV / 2 - 1) @(negedge clk);
			if (tx !== 1'b0) begin
				fail_run("Start bit ended before mid-bit");
			end
			for (int b = 0; b < 8; b++) begin
				repeat (BAUD_DIV) @(negedge clk);
				data[b] = tx;
			end
			repeat (BAUD_DIV) @(negedge clk);
			if (tx !== 1'b1) begin
				fail_run($sformatf("Missing stop bit on character %0d", chars_decoded));
			end
			rx_q.push_back(data);
			chars_decoded++;
		end
	end

	always @(negedge clk) begin
		if (rx_q.size() != 0) begin
			if (exp_q.size() == 0) begin
				fail_run("Character received with nothing expected");
			end
			check_char(rx_q.pop_front(), exp_q.pop_front(), n_compared);
			n_compared++;
		end
	end

endmodule

/* testbench/tb_clock.sv */
module tb_clock (
	output logic clk,
	output logic rst
);

	localparam int PERIOD       = 40;
	localparam int RESET_CYCLES = 5;

	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD / 2) clk = ~clk;
		end
	end

	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

/* rtl/cpu_trace.sv */
module cpu_trace import trace_pkg::*, uart_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  trace_rec_t cpu,
	output logic       halt,
	output logic       tx
);

	logic       capture;
	logic       wr;
	logic       empty;
	logic       credit;
	field_sel_e field;
	char_line_t line;
	tx_byte_t   tx_byte;

	trace_ctrl ctrl_i (
		.clk     (clk),
		.rst     (rst),
		.instr   (cpu.instr),
		.empty   (empty),
		.halt    (halt),
		.capture (capture),
		.wr      (wr),
		.field   (field)
	);

	hex_line_fmt fmt_i (
		.clk     (clk),
		.rst     (rst),
		.cpu     (cpu),
		.capture (capture),
		.field   (field),
		.line    (line)
	);

	char_fifo fifo_i (
		.clk     (clk),
		.rst     (rst),
		.wr      (wr),
		.line    (line),
		.empty   (empty),
		.credit  (credit),
		.tx_byte (tx_byte)
	);

	uart_tx tx_i (
		.clk     (clk),
		.rst     (rst),
		.tx_byte (tx_byte),
		.credit  (credit),
		.tx      (tx)
	);

endmodule

/* rtl/uart_tx.sv */
module uart_tx import uart_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  tx_byte_t tx_byte,
	output logic     credit,
	output logic     tx
);

	logic       hold_valid;
	uart_char_t hold_data;
	logic       busy;
	logic [9:0] shift;
	logic [3:0] bit_cnt;
	logic [$clog2(BAUD_DIV)-1:0] baud_cnt;
	logic       bit_end;
	logic       frame_end;
	logic       load;

	assign bit_end   = busy && (baud_cnt == $bits(baud_cnt)'(BAUD_DIV - 1));
	// Stop bit is the tenth
	assign frame_end = bit_end && (bit_cnt == 4'd9);

	// Reload straight off the stop bit keeps frames back to back
	assign load   = hold_valid && (!busy || frame_end);
	// A slot frees up as each frame leaves the line
	assign credit = frame_end;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			hold_valid <= 1'b0;
		end else if (tx_byte.valid) begin
			hold_valid <= 1'b1;
		end else if (load) begin
			hold_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (tx_byte.valid) begin
			hold_data <= tx_byte.data;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy     <= 1'b0;
			bit_cnt  <= '0;
			baud_cnt <= '0;
		end else if (load) begin
			busy     <= 1'b1;
			bit_cnt  <= '0;
			baud_cnt <= '0;
		end else if (busy) begin
			if (bit_end) begin
				baud_cnt <= '0;
				bit_cnt  <= bit_cnt + 1'b1;
				if (frame_end) begin
					busy <= 1'b0;
				end
			end else begin
				baud_cnt <= baud_cnt + 1'b1;
			end
		end
	end

	// Stop, data LSB first, start
	always_ff @(posedge clk) begin
		if (load) begin
			shift <= {1'b1, hold_data, 1'b0};
		end else if (bit_end) begin
			shift <= {1'b1, shift[9:1]};
		end
	end

	assign tx = busy ? shift[0] : 1'b1;

	// Sender keeps within its credits
	a_no_overrun: assert property (
		@(posedge clk) disable iff (rst)
		tx_byte.valid |-> !(hold_valid && busy)
	);

endmodule

/* rtl/char_fifo.sv */
module char_fifo import trace_pkg::*, uart_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       wr,
	input  char_line_t line,
	output logic       empty,
	input  logic       credit,
	output tx_byte_t   tx_byte
);

	char_line_t mem [FIFO_LINES];

	logic [$clog2(FIFO_LINES)-1:0]     wr_ptr;
	logic [$clog2(FIFO_LINES)-1:0]     rd_ptr;
	logic [$clog2(FIFO_LINES+1)-1:0]   count;
	logic [$clog2(LINE_CHARS)-1:0]     char_idx;
	logic [$clog2(UART_CREDITS+1)-1:0] credits;
	logic       offer;
	logic       pop;
	logic       tx_valid;
	uart_char_t tx_data;

	assign empty = (count == '0);

	// Send only with a credit in hand
	assign offer = !empty && (credits != '0);

	// Head line leaves after its last character
	assign pop = offer && (char_idx == '0);

	always_ff @(posedge clk) begin
		if (wr) begin
			mem[wr_ptr] <= line;
		end
	end

	always_ff @(posedge clk) begin
		if (offer) begin
			tx_data <= mem[rd_ptr][char_idx];
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			char_idx <= $bits(char_idx)'(LINE_CHARS - 1);
			credits  <= $bits(credits)'(UART_CREDITS);
			tx_valid <= 1'b0;
		end else begin
			tx_valid <= offer;
			if (wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr   <= rd_ptr + 1'b1;
				char_idx <= $bits(char_idx)'(LINE_CHARS - 1);
			end else if (offer) begin
				char_idx <= char_idx - 1'b1;
			end
			case ({wr, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			case ({credit, offer})
				2'b10:   credits <= credits + 1'b1;
				2'b01:   credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	assign tx_byte = '{valid: tx_valid, data: tx_data};

	// Controller must only write with room left
	a_no_overflow: assert property (
		@(posedge clk) disable iff (rst)
		wr |-> (count != $bits(count)'(FIFO_LINES))
	);

	// A returned credit never lifts the count above the slot total
	a_credit_bound: assert property (
		@(posedge clk) disable iff (rst)
		(credit && !offer) |-> (credits < $bits(credits)'(UART_CREDITS))
	);

endmodule

/* rtl/hex_line_fmt.sv */
module hex_line_fmt import trace_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  trace_rec_t cpu,
	input  logic       capture,
	input  field_sel_e field,
	output char_line_t line
);

	trace_rec_t  snap;
	logic [31:0] word;

	// Uppercase hex digit
	function automatic logic [7:0] hex_ascii(input logic [3:0] nib);
		logic [7:0] code;
		if (nib < 4'd10) begin
			code = 8'h30 + {4'h0, nib};
		end else begin
			code = 8'h37 + {4'h0, nib};
		end
		return code;
	endfunction

	// Record is taken on the retire edge
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			snap <= '0;
		end else if (capture) begin
			snap <= cpu;
		end
	end

	always_comb begin
		case (field)
			FIELD_ADDR: word = snap.mem_addr;
			FIELD_DATA: word = snap.mem_wdata;
			default:    word = snap.instr;
		endcase
	end

	always_comb begin
		for (int i = 0; i < LINE_CHARS; i++) begin
			line[i] = hex_ascii(word[4*i +: 4]);
		end
		if (field == FIELD_FLAG) begin
			for (int i = 3; i < LINE_CHARS; i++) begin
				line[i] = 8'h30;
			end
			line[2] = hex_ascii({3'b000, snap.mem_wr});
			// CR LF closes the record
			line[1] = 8'h0d;
			line[0] = 8'h0a;
		end
	end

endmodule

/* rtl/trace_ctrl.sv */
module trace_ctrl import trace_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic [31:0] instr,
	input  logic        empty,
	output logic        halt,
	output logic        capture,
	output logic        wr,
	output field_sel_e  field
);

	trace_state_e state;
	trace_state_e state_next;
	logic         traceable;

	// A halt opcode is never granted, so the core stays stopped on it
	assign traceable = (instr[31:26] != HALT_OPCODE);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= ST_WAIT;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			ST_WAIT: begin
				if (empty && traceable) begin
					state_next = ST_RUN;
				end
			end
			ST_RUN:        state_next = ST_EMIT_INSTR;
			ST_EMIT_INSTR: state_next = ST_EMIT_ADDR;
			ST_EMIT_ADDR:  state_next = ST_EMIT_DATA;
			ST_EMIT_DATA:  state_next = ST_EMIT_FLAG;
			ST_EMIT_FLAG:  state_next = ST_WAIT;
			default:       state_next = ST_WAIT;
		endcase
	end

	// Core only runs for the single ST_RUN cycle
	assign halt    = (state != ST_RUN);
	assign capture = (state == ST_RUN);
	assign wr      = (state == ST_EMIT_INSTR) || (state == ST_EMIT_ADDR) ||
	                 (state == ST_EMIT_DATA)  || (state == ST_EMIT_FLAG);

	always_comb begin
		case (state)
			ST_EMIT_ADDR: field = FIELD_ADDR;
			ST_EMIT_DATA: field = FIELD_DATA;
			ST_EMIT_FLAG: field = FIELD_FLAG;
			default:      field = FIELD_INSTR;
		endcase
	end

	// Core held on each write, and the line lands in the FIFO
	a_wr_held: assert property (
		@(posedge clk) disable iff (rst)
		wr |-> halt ##1 !empty
	);

endmodule

/* rtl/uart_pkg.sv */
package uart_pkg;

	// Clocks per serial bit
	localparam int BAUD_DIV = 8;

	// Slots in the transmitter, so also the credits held by the sender
	localparam int UART_CREDITS = 2;

	typedef logic [7:0] uart_char_t;

	typedef struct packed {
		logic       valid;
		uart_char_t data;
	} tx_byte_t;

endpackage

/* rtl/trace_pkg.sv */
package trace_pkg;

	// Opcode field of an instruction that stops the core for good
	localparam logic [5:0] HALT_OPCODE = 6'd0;

	localparam int FIFO_LINES = 4;
	localparam int LINE_CHARS = 8;

	// One retired instruction as seen by the trace port
	typedef struct packed {
		logic [31:0] instr;
		logic [31:0] mem_addr;
		logic [31:0] mem_wdata;
		logic        mem_wr;
	} trace_rec_t;

	// Index LINE_CHARS-1 is the first character on the line
	typedef logic [LINE_CHARS-1:0][7:0] char_line_t;

	typedef enum logic [1:0] {
		FIELD_INSTR,
		FIELD_ADDR,
		FIELD_DATA,
		FIELD_FLAG
	} field_sel_e;

	typedef enum logic [2:0] {
		ST_WAIT,
		ST_RUN,
		ST_EMIT_INSTR,
		ST_EMIT_ADDR,
		ST_EMIT_DATA,
		ST_EMIT_FLAG
	} trace_state_e;

endpackage
